//--- tb.f
+incdir+sim
design/loop_pkg.sv
design/loop_if.sv
design/loop_csr.sv
design/iter_alloc.sv
design/loop_worker.sv
design/result_reduce.sv
design/loop_top.sv
sim/tb_loop.sv

//--- Makefile
# Verilator build for the loop dispatcher testbench

VERILATOR ?= verilator
TOP ?= tb_loop
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_STR ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_STR)'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_axil_tasks.svh
// Host side of the AXI4-Lite bus, inputs change on the rising edge

task automatic write_reg(
	input loop_pkg::addr_t a,
	input loop_pkg::word_t d,
	input logic [3:0] strb,
	input logic [1:0] exp_resp
);
	logic aw_done;
	logic w_done;
	int dly;
	aw_done = 1'b0;
	w_done = 1'b0;
	@(posedge clk);
	awaddr <= a;
	awvalid <= 1'b1;
	wdata <= d;
	wstrb <= strb;
	wvalid <= 1'b1;
	while (!(aw_done && w_done)) begin
		@(posedge clk);
		if (!aw_done && awready) begin
			aw_done = 1'b1;
			awvalid <= 1'b0;
		end
		if (!w_done && wready) begin
			w_done = 1'b1;
			wvalid <= 1'b0;
		end
	end
	// Random back-pressure on the response
	dly = $urandom_range(3, 0);
	repeat (dly) @(posedge clk);
	bready <= 1'b1;
	do begin
		@(posedge clk);
	end while (!bvalid);
	bready <= 1'b0;
	compare("bresp", loop_pkg::word_t'(bresp), loop_pkg::word_t'(exp_resp));
endtask

task automatic read_reg(
	input loop_pkg::addr_t a,
	output loop_pkg::word_t d,
	input logic [1:0] exp_resp
);
	int dly;
	@(posedge clk);
	araddr <= a;
	arvalid <= 1'b1;
	do begin
		@(posedge clk);
	end while (!arready);
	arvalid <= 1'b0;
	dly = $urandom_range(3, 0);
	repeat (dly) @(posedge clk);
	rready <= 1'b1;
	do begin
		@(posedge clk);
	end while (!rvalid);
	rready <= 1'b0;
	d = rdata;
	compare("rresp", loop_pkg::word_t'(rresp), loop_pkg::word_t'(exp_resp));
endtask

//--- sim/tb_loop.sv
`timescale 1ns/100ps

module tb_loop;
	logic clk;
	logic rst_n;
	loop_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;
	loop_pkg::word_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	loop_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	loop_pkg::word_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// One loop per row with its expected sum from the model
	typedef struct packed {
		loop_pkg::word_t start;
		loop_pkg::word_t stride;
		loop_pkg::word_t count;
		logic rego;
		loop_pkg::word_t exp_sum;
	} row_t;

	row_t rows[$];
	int n_checks;
	int n_errors;
	int limit;
	loop_pkg::word_t rd;

	loop_top u_loop_top (.*);

	always #2 clk = ~clk;

	task automatic compare(
		input string name,
		input loop_pkg::word_t got,
		input loop_pkg::word_t exp
	);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	`include "tb_axil_tasks.svh"

	// Sum of the squares of start + k*stride modulo 2^32
	function automatic loop_pkg::word_t square_sum(
		input loop_pkg::word_t start,
		input loop_pkg::word_t stride,
		input loop_pkg::word_t count
	);
		loop_pkg::word_t acc;
		loop_pkg::word_t v;
		acc = '0;
		for (int unsigned k = 0; k < count; k++) begin
			v = start + loop_pkg::word_t'(k) * stride;
			acc = acc + v * v;
		end
		return acc;
	endfunction

	task automatic add_row(
		input loop_pkg::word_t start,
		input loop_pkg::word_t stride,
		input loop_pkg::word_t count,
		input logic rego
	);
		row_t r;
		r.start = start;
		r.stride = stride;
		r.count = count;
		r.rego = rego;
		r.exp_sum = square_sum(start, stride, count);
		rows.push_back(r);
	endtask

	task automatic run_row(input row_t r);
		write_reg(loop_pkg::REG_START, r.start, 4'hF, loop_pkg::RESP_OKAY);
		write_reg(loop_pkg::REG_STRIDE, r.stride, 4'hF, loop_pkg::RESP_OKAY);
		write_reg(loop_pkg::REG_COUNT, r.count, 4'hF, loop_pkg::RESP_OKAY);
		write_reg(loop_pkg::REG_CTRL, 32'd1, 4'hF, loop_pkg::RESP_OKAY);
		if (r.rego) begin
			// A restart while busy would pick up the new START
			write_reg(loop_pkg::REG_START, ~r.start, 4'hF, loop_pkg::RESP_OKAY);
			write_reg(loop_pkg::REG_CTRL, 32'd1, 4'hF, loop_pkg::RESP_OKAY);
		end
		do begin
			read_reg(loop_pkg::REG_CTRL, rd, loop_pkg::RESP_OKAY);
		end while (!rd[1]);
		compare("busy", loop_pkg::word_t'(rd[0]), '0);
		read_reg(loop_pkg::REG_SUM, rd, loop_pkg::RESP_OKAY);
		compare("sum", rd, r.exp_sum);
	endtask

	initial begin
		void'($urandom(80));
		clk = 1'b0;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		n_checks = 0;
		n_errors = 0;

		add_row(32'd3, 32'd5, 32'd8, 1'b0);
		add_row(32'd100, loop_pkg::word_t'(-7), 32'd11, 1'b0);
		add_row(32'd9, 32'd2, 32'd0, 1'b0);
		add_row(32'd7, 32'd3, 32'd12, 1'b1);
		repeat (2) add_row($urandom, $urandom, $urandom_range(9, 1), 1'b0);

		// Budget per row plus room for the register tests
		limit = 100;
		foreach (rows[i])
			limit += 100 + 40 * int'(rows[i].count) / loop_pkg::N_WORKER;
		fork
			begin
				repeat (limit) @(posedge clk);
				$display("Timeout after %0d cycles, the DUT stopped responding", limit);
				$display(">>> FAIL");
				$finish;
			end
		join_none

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// Partial strobes keep the untouched byte lanes
		write_reg(loop_pkg::REG_START, 32'hAABB_CCDD, 4'hF, loop_pkg::RESP_OKAY);
		write_reg(loop_pkg::REG_START, 32'h1122_3344, 4'b0101, loop_pkg::RESP_OKAY);
		read_reg(loop_pkg::REG_START, rd, loop_pkg::RESP_OKAY);
		compare("start", rd, 32'hAA22_CC44);
		write_reg(loop_pkg::REG_STRIDE, 32'h1234_5678, 4'hF, loop_pkg::RESP_OKAY);
		read_reg(loop_pkg::REG_STRIDE, rd, loop_pkg::RESP_OKAY);
		compare("stride", rd, 32'h1234_5678);
		write_reg(loop_pkg::REG_COUNT, 32'h0000_0F0F, 4'hF, loop_pkg::RESP_OKAY);
		write_reg(loop_pkg::REG_COUNT, 32'hFFFF_FFFF, 4'b1000, loop_pkg::RESP_OKAY);
		read_reg(loop_pkg::REG_COUNT, rd, loop_pkg::RESP_OKAY);
		compare("count", rd, 32'hFF00_0F0F);

		// Unmapped and misaligned offsets
		write_reg(5'h14, 32'h0000_DEAD, 4'hF, loop_pkg::RESP_SLVERR);
		read_reg(5'h1C, rd, loop_pkg::RESP_SLVERR);
		read_reg(5'h06, rd, loop_pkg::RESP_SLVERR);

		foreach (rows[i])
			run_row(rows[i]);

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- design/loop_top.sv
`timescale 1ns/100ps

module loop_top (
	input logic clk,
	input logic rst_n,
	input loop_pkg::addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input loop_pkg::word_t wdata,
	input logic [loop_pkg::WORD_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input loop_pkg::addr_t araddr,
	input logic arvalid,
	output logic arready,
	output loop_pkg::word_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);
	logic go, busy, done;
	loop_pkg::word_t start, stride, count, sum;

	idx_if ix [loop_pkg::N_WORKER] ();
	res_if rs [loop_pkg::N_WORKER] ();

	loop_csr u_csr (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.go, .start, .stride, .count,
		.sum, .busy, .done
	);

	iter_alloc u_alloc (.clk, .rst_n, .go, .start, .stride, .count, .ix(ix));

	for (genvar i = 0; i < loop_pkg::N_WORKER; i++) begin : g_worker
		loop_worker u_worker (.clk, .rst_n, .ix(ix[i]), .rs(rs[i]));
	end

	result_reduce u_reduce (.clk, .rst_n, .go, .count, .rs(rs), .sum, .busy, .done);

endmodule

//--- design/result_reduce.sv
`timescale 1ns/100ps

module result_reduce (
	input logic clk,
	input logic rst_n,
	input logic go,
	input loop_pkg::word_t count,
	res_if.dst rs [loop_pkg::N_WORKER],
	output loop_pkg::word_t sum,
	output logic busy,
	output logic done
);
	logic [loop_pkg::N_WORKER-1:0] valid_v, ready_v;
	loop_pkg::word_t value_v [loop_pkg::N_WORKER];
	loop_pkg::wid_t ptr, sel;
	loop_pkg::word_t ncomp;
	logic found, xfer;

	for (genvar i = 0; i < loop_pkg::N_WORKER; i++) begin : g_port
		assign valid_v[i] = rs[i].valid;
		assign value_v[i] = rs[i].value;
		assign rs[i].ready = ready_v[i];
	end

	// First valid worker at or after the pointer
	always_comb begin
		found = 1'b0;
		sel = ptr;
		for (int k = loop_pkg::N_WORKER - 1; k >= 0; k--) begin
			if (valid_v[(int'(ptr) + k) % loop_pkg::N_WORKER]) begin
				found = 1'b1;
				sel = loop_pkg::wid_t'((int'(ptr) + k) % loop_pkg::N_WORKER);
			end
		end
	end

	assign xfer = found && busy;

	always_comb begin
		ready_v = '0;
		if (xfer)
			ready_v[sel] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
			sum <= '0;
			ncomp <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else if (go) begin
			sum <= '0;
			ncomp <= '0;
			// Empty loop finishes right away
			busy <= (count != '0);
			done <= (count == '0);
		end else if (busy) begin
			if (xfer) begin
				sum <= sum + value_v[sel];
				ncomp <= ncomp + 1'b1;
				ptr <= loop_pkg::wid_t'((int'(sel) + 1) % loop_pkg::N_WORKER);
			end
			if (ncomp + loop_pkg::word_t'(xfer) == count) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(ready_v));

endmodule

//--- design/loop_worker.sv
`timescale 1ns/100ps

module loop_worker (
	input logic clk,
	input logic rst_n,
	idx_if.worker ix,
	res_if.src rs
);
	loop_pkg::w_state_t state;
	loop_pkg::word_t mcand, mplr, acc;
	logic [$clog2(loop_pkg::WORD_W)-1:0] step;

	assign ix.req = (state == loop_pkg::W_IDLE) && !ix.stop;
	assign rs.valid = (state == loop_pkg::W_OFFER);
	assign rs.value = acc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= loop_pkg::W_IDLE;
			step <= '0;
		end else begin
			case (state)
				loop_pkg::W_IDLE: begin
					if (ix.grant) begin
						state <= loop_pkg::W_CALC;
						step <= '0;
					end
				end
				loop_pkg::W_CALC: begin
					step <= step + 1'b1;
					if (step == '1)
						state <= loop_pkg::W_OFFER;
				end
				loop_pkg::W_OFFER: begin
					if (rs.ready)
						state <= loop_pkg::W_IDLE;
				end
				default: state <= loop_pkg::W_IDLE;
			endcase
		end
	end

	// Shift-add square, one multiplier bit per cycle
	always_ff @(posedge clk) begin
		if (state == loop_pkg::W_IDLE && ix.grant) begin
			mcand <= ix.idx;
			mplr <= ix.idx;
			acc <= '0;
		end else if (state == loop_pkg::W_CALC) begin
			if (mplr[0])
				acc <= acc + mcand;
			mcand <= mcand << 1;
			mplr <= mplr >> 1;
		end
	end

endmodule

//--- design/iter_alloc.sv
`timescale 1ns/100ps

module iter_alloc (
	input logic clk,
	input logic rst_n,
	input logic go,
	input loop_pkg::word_t start,
	input loop_pkg::word_t stride,
	input loop_pkg::word_t count,
	idx_if.alloc ix [loop_pkg::N_WORKER]
);
	loop_pkg::word_t base, remain;
	loop_pkg::word_t n_grant, offs;
	logic [loop_pkg::N_WORKER-1:0] req_v, grant_v;
	loop_pkg::word_t idx_v [loop_pkg::N_WORKER];

	for (genvar i = 0; i < loop_pkg::N_WORKER; i++) begin : g_port
		assign req_v[i] = ix[i].req;
		assign ix[i].grant = grant_v[i];
		assign ix[i].idx = idx_v[i];
		assign ix[i].stop = (remain == '0);
	end

	// Prefix sum over requesters in worker order
	always_comb begin
		n_grant = '0;
		offs = '0;
		for (int i = 0; i < loop_pkg::N_WORKER; i++) begin
			grant_v[i] = req_v[i] && (n_grant < remain);
			idx_v[i] = base + offs;
			if (grant_v[i]) begin
				n_grant = n_grant + 1'b1;
				offs = offs + stride;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			base <= '0;
			remain <= '0;
		end else if (go) begin
			base <= start;
			remain <= count;
		end else begin
			// Advance past every index handed out this cycle
			base <= base + offs;
			remain <= remain - n_grant;
		end
	end

	a_no_overgrant: assert property (@(posedge clk) disable iff (!rst_n)
		n_grant <= remain);

endmodule

//--- design/loop_csr.sv
`timescale 1ns/100ps

module loop_csr (
	input logic clk,
	input logic rst_n,
	input loop_pkg::addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input loop_pkg::word_t wdata,
	input logic [loop_pkg::WORD_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input loop_pkg::addr_t araddr,
	input logic arvalid,
	output logic arready,
	output loop_pkg::word_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic go,
	output loop_pkg::word_t start,
	output loop_pkg::word_t stride,
	output loop_pkg::word_t count,
	input loop_pkg::word_t sum,
	input logic busy,
	input logic done
);
	logic aw_held, w_held;
	loop_pkg::addr_t awaddr_q, wr_addr;
	loop_pkg::word_t wdata_q, wr_data;
	logic [loop_pkg::WORD_W/8-1:0] wstrb_q, wr_strb;
	logic aw_hs, w_hs, aw_ok, w_ok, wr_en, ar_hs;

	function automatic logic is_mapped(input loop_pkg::addr_t a);
		return (a[1:0] == 2'b00) && (a <= loop_pkg::REG_SUM);
	endfunction

	function automatic loop_pkg::word_t merge_bytes(
		input loop_pkg::word_t old_v,
		input loop_pkg::word_t new_v,
		input logic [loop_pkg::WORD_W/8-1:0] strb
	);
		loop_pkg::word_t res;
		res = old_v;
		for (int b = 0; b < loop_pkg::WORD_W / 8; b++) begin
			if (strb[b])
				res[b*8 +: 8] = new_v[b*8 +: 8];
		end
		return res;
	endfunction

	// One transaction per channel, nothing new while a response is pending
	assign awready = !aw_held && !bvalid;
	assign wready = !w_held && !bvalid;
	assign arready = !rvalid;

	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign ar_hs = arvalid && arready;
	assign aw_ok = aw_held || aw_hs;
	assign w_ok = w_held || w_hs;
	assign wr_en = aw_ok && w_ok;

	assign wr_addr = aw_held ? awaddr_q : awaddr;
	assign wr_data = w_held ? wdata_q : wdata;
	assign wr_strb = w_held ? wstrb_q : wstrb;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			go <= 1'b0;
			start <= '0;
			stride <= '0;
			count <= '0;
		end else begin
			// Hold whichever half arrived first
			aw_held <= aw_ok && !w_ok;
			w_held <= w_ok && !aw_ok;
			if (wr_en)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (ar_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			// Go while busy is dropped
			go <= wr_en && (wr_addr == loop_pkg::REG_CTRL) && wr_strb[0] && wr_data[0]
				&& !busy;
			if (wr_en) begin
				case (wr_addr)
					loop_pkg::REG_START: start <= merge_bytes(start, wr_data, wr_strb);
					loop_pkg::REG_STRIDE: stride <= merge_bytes(stride, wr_data, wr_strb);
					loop_pkg::REG_COUNT: count <= merge_bytes(count, wr_data, wr_strb);
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			awaddr_q <= awaddr;
		if (w_hs) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
		if (wr_en)
			bresp <= is_mapped(wr_addr) ? loop_pkg::RESP_OKAY : loop_pkg::RESP_SLVERR;
		if (ar_hs) begin
			rresp <= is_mapped(araddr) ? loop_pkg::RESP_OKAY : loop_pkg::RESP_SLVERR;
			case (araddr)
				loop_pkg::REG_START: rdata <= start;
				loop_pkg::REG_STRIDE: rdata <= stride;
				loop_pkg::REG_COUNT: rdata <= count;
				loop_pkg::REG_CTRL: rdata <= {{(loop_pkg::WORD_W-2){1'b0}}, done, busy};
				loop_pkg::REG_SUM: rdata <= sum;
				default: rdata <= '0;
			endcase
		end
	end

	// Write response held until the host takes it
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);

endmodule

//--- design/loop_if.sv
`timescale 1ns/100ps

// Index request path, worker to allocator
interface idx_if;
	logic req;
	logic grant;
	loop_pkg::word_t idx;
	// High while no loop is running
	logic stop;

	modport alloc (
		input req,
		output grant,
		output idx,
		output stop
	);

	modport worker (
		output req,
		input grant,
		input idx,
		input stop
	);
endinterface

// Result path, worker to reducer
interface res_if;
	logic valid;
	logic ready;
	loop_pkg::word_t value;

	modport src (
		output valid,
		output value,
		input ready
	);

	modport dst (
		input valid,
		input value,
		output ready
	);
endinterface

//--- design/loop_pkg.sv
package loop_pkg;

	// Sizes
	localparam int N_WORKER = 4;
	localparam int WORD_W = 32;
	localparam int ADDR_W = 5;

	// Indices, strides, counts, results and the sum
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [$clog2(N_WORKER)-1:0] wid_t;

	// Register map, one word each
	localparam addr_t REG_START = 5'h00;
	localparam addr_t REG_STRIDE = 5'h04;
	localparam addr_t REG_COUNT = 5'h08;
	// Write bit 0 for go, read bit 0 busy and bit 1 done
	localparam addr_t REG_CTRL = 5'h0C;
	localparam addr_t REG_SUM = 5'h10;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// Worker FSM
	typedef enum logic [1:0] {
		W_IDLE,
		W_CALC,
		W_OFFER
	} w_state_t;

endpackage
